// ==== sample_collect_top.f ====
hdl/sample_pkg.sv
hdl/sample_fifo.sv
hdl/channel_sample_bank.sv
hdl/sample_collector.sv
hdl/sample_collect_top.sv
bench/sample_collect_assertions.sv
bench/sample_collect_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the sampling-storage testbench with Verilator, runs it and
# decides pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module sample_collect_tb -f sample_collect_top.f \
    -Mdir obj_dir -o sample_collect_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/sample_collect_sim > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi

cat sim.log

if grep -q "All checks passed" sim.log; then
  exit 0
fi
echo "Simulation did not pass"
exit 1

// ==== bench/sample_collect_tb.sv ====
`timescale 1ns/1ns
// Sampling-storage subsystem testbench.
// Registers units over the command bus, runs the collector for a known
// number of visits and drains the FIFO against a reference model.
module sample_collect_tb;

  localparam int position        = 242;
  localparam int fifo_depth_log2 = 4;
  localparam int num_sources     = 8;
  localparam int fifo_depth      = 2**fifo_depth_log2;
  localparam int rst_cycles      = 10;
  localparam int total_visits    = 12 + 9 + 9 + 6 + 24; // Visits of all five runs.
  localparam int timeout_cycles  = rst_cycles + 4*total_visits + 5*40 + 150;

  logic                     clk = 1'b0;
  logic                     rst;
  sample_pkg::cmd_bus_t     cmd;
  sample_pkg::sample_t      unit_samples [num_sources];
  logic                     fifo_rd;
  sample_pkg::fifo_word_t   fifo_dout;
  sample_pkg::fifo_status_t fifo_flags;

  logic [31:0]            lfsr = 32'h4d280e8c; // Random stream for sample values.
  sample_pkg::channel_t   ref_ch   [16];       // Reference copy of the unit list.
  sample_pkg::sample_t    ref_last [16];       // Reference last stored samples.
  int                     ref_n = 0;           // Registered units.
  int                     ref_idx = 0;         // Next unit to be visited.
  sample_pkg::fifo_word_t exp_q [$];           // Predicted FIFO contents.
  int errors = 0;
  int checks = 0;
  int cycle_count = 0;
  int drain_requests = 0;
  int drains_done = 0;

  sample_collect_top #(
    .position       (position),
    .fifo_depth_log2(fifo_depth_log2),
    .num_sources    (num_sources)
  ) i_dut (
    .clk         (clk),
    .rst         (rst),
    .cmd         (cmd),
    .unit_samples(unit_samples),
    .fifo_rd     (fifo_rd),
    .fifo_dout   (fifo_dout),
    .fifo_flags  (fifo_flags)
  );

  always #4 clk = ~clk; // 8 ns period.

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
      $display("Checks failed");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // Galois form.
  endfunction

  function automatic sample_pkg::sample_t next_random();
    sample_pkg::sample_t value;
    value = '0;
    for (int b = 0; b < 32; b++) begin
      value = {value[30:0], lfsr[0]}; // One LFSR step per bit taken.
      lfsr  = lfsr_step(lfsr);
    end
    return value;
  endfunction

  // Value the bank hands out for a channel. It is zero when no input carries the channel.
  function automatic sample_pkg::sample_t bank_value(input sample_pkg::channel_t ch);
    return (ch < num_sources) ? unit_samples[ch] : '0;
  endfunction

  // Reference model that walks the unit list for a number of visits.
  function automatic void predict_visits(input int count);
    sample_pkg::sample_t s;
    for (int v = 0; v < count; v++) begin
      s = bank_value(ref_ch[ref_idx]);
      if (s != ref_last[ref_idx]) begin
        if (exp_q.size() < fifo_depth) begin
          exp_q.push_back(sample_pkg::fifo_word_t'({3'(ref_idx), s[12:0]}));
        end
        ref_last[ref_idx] = s; // Kept even when the FIFO drops the word.
      end
      ref_idx = (ref_idx + 1) % ref_n;
    end
  endfunction

  function automatic sample_pkg::fifo_status_t expected_flags(input int count);
    sample_pkg::fifo_status_t f;
    f.empty        = (count == 0);
    f.almost_empty = (count <= 1);
    f.full         = (count == fifo_depth);
    f.almost_full  = (count >= fifo_depth - 1);
    return f;
  endfunction

  task automatic check_word(input sample_pkg::fifo_word_t got,
                            input sample_pkg::fifo_word_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("error %0t fifo_dout got %h expected %h", $time, got, want);
    end
  endtask

  task automatic check_flags(input sample_pkg::fifo_status_t got,
                             input sample_pkg::fifo_status_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("error %0t fifo_flags got %b expected %b", $time, got, want);
    end
  endtask

  // One write cycle on the command bus. It starts and ends on a falling edge.
  task automatic bus_write(input logic [7:0] pos, input logic [7:0] offset,
                           input sample_pkg::cmd_data_t data);
    cmd.addr = {pos, offset};
    cmd.data = data;
    cmd.cs   = 1'b1;
    cmd.wr   = 1'b1;
    @(negedge clk);
    cmd = '0;
  endtask

  task automatic register_unit(input sample_pkg::channel_t ch);
    bus_write(8'(position), sample_pkg::addr_new_unit, 32'(ch));
    ref_ch[ref_n] = ch;
    ref_n++;
  endtask

  task automatic clear_units();
    bus_write(8'(position), sample_pkg::addr_local_command, sample_pkg::cmd_reset);
    repeat (3) @(negedge clk); // Lets the reset command settle before new writes.
    ref_n   = 0;
    ref_idx = 0;
    for (int i = 0; i < 16; i++) begin
      ref_last[i] = '0;
    end
  endtask

  task automatic randomize_inputs();
    for (int i = 0; i < num_sources; i++) begin
      unit_samples[i] = next_random() | 32'h1; // Never zero.
    end
  endtask

  // Stop lands four cycles per visit after start, so exactly this many visits run.
  task automatic run_visits(input int visits, input int change_at);
    predict_visits((change_at < 0) ? visits : change_at);
    bus_write(8'(position), sample_pkg::addr_local_command, sample_pkg::cmd_start);
    for (int c = 1; c < 4*visits; c++) begin
      if (c == 4*change_at + 3) begin
        randomize_inputs(); // Seen from visit change_at onward.
        predict_visits(visits - change_at);
      end
      @(negedge clk);
    end
    bus_write(8'(position), sample_pkg::addr_local_command, sample_pkg::cmd_stop);
    repeat (8) @(negedge clk);
  endtask

  task automatic collect_results();
    check_flags(fifo_flags, expected_flags(exp_q.size()));
    drain_requests++;
    wait (drains_done == drain_requests);
  endtask

  task automatic drain_fifo();
    sample_pkg::fifo_word_t want;
    while (exp_q.size() > 0) begin
      want = exp_q.pop_front();
      if (fifo_flags.empty) begin
        errors++;
        $display("FIFO ran empty at %0t with %0d words still expected", $time, exp_q.size() + 1);
        exp_q.delete();
      end else begin
        check_flags(fifo_flags, expected_flags(exp_q.size() + 1)); // Occupancy before the read.
        check_word(fifo_dout, want);
        fifo_rd = 1'b1;
        @(negedge clk);
        fifo_rd = 1'b0;
      end
    end
    check_flags(fifo_flags, expected_flags(0)); // Nothing may be left over.
  endtask

  initial begin
    forever begin
      wait (drain_requests > drains_done);
      drain_fifo();
      drains_done++;
    end
  end

  initial begin
    rst     = 1'b1;
    cmd     = '0;
    fifo_rd = 1'b0;
    for (int i = 0; i < num_sources; i++) begin
      unit_samples[i] = '0;
    end
    repeat (rst_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_flags(fifo_flags, expected_flags(0)); // Empty after reset.

    randomize_inputs(); // Static nonzero inputs give one word per unit.
    register_unit(8'd2);
    register_unit(8'd5);
    register_unit(8'd0);
    run_visits(12, -1);
    collect_results();

    unit_samples[6] = '0;
    register_unit(8'd6); // Zero input.
    register_unit(8'd9); // Channel beyond the sources reads as zero.
    bus_write(8'(position + 1), sample_pkg::addr_new_unit, 32'd3); // Other block.
    run_visits(9, -1);
    collect_results();

    unit_samples[5] = next_random() | 32'h1; // Only units 1 and 3 change.
    unit_samples[6] = next_random() | 32'h1;
    run_visits(9, -1);
    collect_results();

    clear_units();
    register_unit(8'd2); // Same values as before count as new after the reset.
    register_unit(8'd5);
    run_visits(6, -1);
    collect_results();

    clear_units();
    randomize_inputs();
    for (int i = 0; i < 16; i++) begin
      register_unit(sample_pkg::channel_t'(i % num_sources));
    end
    run_visits(24, 16); // The FIFO fills in the first round and later words are dropped.
    collect_results();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== bench/sample_collect_assertions.sv ====
`timescale 1ns/1ns
// Collector and FIFO assertions.
// Watches the collector strobes against its state and the FIFO flags.
module sample_collect_assertions (
  input logic                       clk,
  input logic                       rst,
  input sample_pkg::collect_state_t state,
  input logic                       sample_strobe,
  input logic                       fifo_wr,
  input sample_pkg::fifo_status_t   flags
);

  // The units are only asked for data during the two fetch states.
  assert property (@(posedge clk) disable iff (rst)
    sample_strobe |-> (state == sample_pkg::fetch || state == sample_pkg::fetch_wait))
    else $error("sample_strobe is high outside fetch and fetch_wait.");

  assert property (@(posedge clk) disable iff (rst)
    fifo_wr |-> (state == sample_pkg::store))
    else $error("fifo_wr is high outside store.");

  assert property (@(posedge clk) disable iff (rst)
    fifo_wr |=> !fifo_wr)
    else $error("fifo_wr is high for more than one cycle.");

  assert property (@(posedge clk) disable iff (rst)
    !(flags.full && flags.empty))
    else $error("FIFO reports full and empty at once.");

endmodule

bind sample_collect_top sample_collect_assertions i_assertions (
  .clk          (clk),
  .rst          (rst),
  .state        (i_collector.state),
  .sample_strobe(sample_strobe),
  .fifo_wr      (fifo_wr),
  .flags        (fifo_flags)
);

// ==== hdl/sample_collect_top.sv ====
`timescale 1ns/1ns
// Sampling-storage subsystem top level.
// Ties the collector to the channel bank that stands in for the units and
// to the FIFO that holds changed samples until they are read out.
module sample_collect_top #(
  parameter int position        = 242, // Bus position of the collector window.
  parameter int fifo_depth_log2 = 4,   // FIFO holds two to this power words.
  parameter int num_sources     = 8    // Number of external sample inputs.
) (
  input  logic                     clk,
  input  logic                     rst,
  input  sample_pkg::cmd_bus_t     cmd,
  input  sample_pkg::sample_t      unit_samples [num_sources],
  input  logic                     fifo_rd,
  output sample_pkg::fifo_word_t   fifo_dout,
  output sample_pkg::fifo_status_t fifo_flags
);

  logic                   sample_strobe;  // Collector asks the unit for data.
  sample_pkg::channel_t   channel_select; // Channel of the unit being visited.
  sample_pkg::sample_t    sample_data;    // Sample returned by the bank.
  logic                   fifo_wr;
  sample_pkg::fifo_word_t fifo_din;

  sample_collector #(
    .position(position)
  ) i_collector (
    .clk           (clk),
    .rst           (rst),
    .cmd           (cmd),
    .sample_data   (sample_data),
    .sample_strobe (sample_strobe),
    .channel_select(channel_select),
    .fifo_wr       (fifo_wr),
    .fifo_din      (fifo_din)
  );

  channel_sample_bank #(
    .num_sources(num_sources)
  ) i_bank (
    .clk           (clk),
    .rst           (rst),
    .channel_select(channel_select),
    .sample_strobe (sample_strobe),
    .unit_samples  (unit_samples),
    .sample_data   (sample_data)
  );

  sample_fifo #(
    .fifo_depth_log2(fifo_depth_log2)
  ) i_fifo (
    .clk   (clk),
    .rst   (rst),
    .din   (fifo_din),
    .wr    (fifo_wr),
    .rd    (fifo_rd),
    .dout  (fifo_dout),
    .status(fifo_flags)
  );

endmodule

// ==== hdl/sample_collector.sv ====
`timescale 1ns/1ns
// Sample collector.
// Decodes a register window on the command bus, keeps a list of up to
// sixteen collection units and polls them in turn while sampling runs.
// A sample that differs from the unit's last stored value is handed to
// the FIFO as a 3-bit unit index and the low 13 bits of the sample.
module sample_collector #(
  parameter int position = 242 // Block position matched against the upper address byte.
) (
  input  logic                   clk,
  input  logic                   rst,
  input  sample_pkg::cmd_bus_t   cmd,
  input  sample_pkg::sample_t    sample_data,
  output logic                   sample_strobe,
  output sample_pkg::channel_t   channel_select,
  output logic                   fifo_wr,
  output sample_pkg::fifo_word_t fifo_din
);

  // One extra bit so that a completely filled list can be told from an empty one.
  typedef logic [$clog2(sample_pkg::max_units):0] unit_count_t;

  localparam logic [7:0]  block_pos  = 8'(position);
  localparam unit_count_t units_full = unit_count_t'(sample_pkg::max_units);

  sample_pkg::channel_t       unit_list    [sample_pkg::max_units]; // Channel per unit.
  sample_pkg::sample_t        last_fetched [sample_pkg::max_units]; // Last stored sample.
  unit_count_t                num_units;   // Number of registered units.
  sample_pkg::unit_idx_t      cur_idx;     // Unit being visited.
  sample_pkg::unit_idx_t      last_idx;    // Index of the last registered unit.
  sample_pkg::cmd_data_t      command;     // Latched command, cleared once acted on.
  sample_pkg::collect_state_t state;
  sample_pkg::collect_state_t next_state;

  logic block_sel;      // Bus write addressed to this block.
  logic new_unit_wr;    // Write to the new-unit register with room left.
  logic command_wr;     // Write to the local command register.
  logic sample_changed; // Presented sample differs from the stored one.
  logic clr_command;    // The latched command has been consumed.
  logic clr_units;      // Reset command, clears list and stored samples.
  logic inc_idx;        // Move on to the next unit.

  // Register window decode.
  assign block_sel   = cmd.cs && cmd.wr && (cmd.addr[15:8] == block_pos);
  assign new_unit_wr = block_sel && (cmd.addr[7:0] == sample_pkg::addr_new_unit) &&
                       (num_units != units_full); // Registrations beyond the list are dropped.
  assign command_wr  = block_sel && (cmd.addr[7:0] == sample_pkg::addr_local_command);

  assign last_idx = sample_pkg::unit_idx_t'(num_units - 1'b1); // Wraps to 15 for a full list.

  assign channel_select = unit_list[cur_idx]; // Held steady for the whole visit.
  assign sample_changed = (sample_data != last_fetched[cur_idx]);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= sample_pkg::idle;
    end else begin
      state <= next_state;
    end
  end

  // Commands are only looked at in idle and increment, so a visit is never cut short.
  always_comb begin
    next_state  = state;
    clr_command = 1'b0;
    clr_units   = 1'b0;
    inc_idx     = 1'b0;
    case (state)
      sample_pkg::idle: begin
        if (command == sample_pkg::cmd_start) begin
          clr_command = 1'b1;
          next_state  = sample_pkg::fetch;
        end else if (command == sample_pkg::cmd_reset) begin
          clr_command = 1'b1;
          clr_units   = 1'b1; // Stays idle with an empty list.
        end else if (command == sample_pkg::cmd_stop) begin
          clr_command = 1'b1; // Already stopped, nothing else to do.
        end
      end
      sample_pkg::fetch: begin
        next_state = sample_pkg::fetch_wait; // Bank captures the channel at the end of this cycle.
      end
      sample_pkg::fetch_wait: begin
        next_state = sample_pkg::store; // Second strobe cycle lets the unit settle its data.
      end
      sample_pkg::store: begin
        next_state = sample_pkg::increment; // The FIFO write happens here when the data changed.
      end
      sample_pkg::increment: begin
        inc_idx = 1'b1;
        if (command == sample_pkg::cmd_reset) begin
          clr_command = 1'b1;
          clr_units   = 1'b1;
          next_state  = sample_pkg::idle;
        end else if (command == sample_pkg::cmd_stop) begin
          clr_command = 1'b1;
          next_state  = sample_pkg::idle;
        end else begin
          next_state = sample_pkg::fetch;
        end
      end
      default: begin
        next_state = sample_pkg::idle;
      end
    endcase
  end

  assign sample_strobe = (state == sample_pkg::fetch) || (state == sample_pkg::fetch_wait);
  assign fifo_wr       = (state == sample_pkg::store) && sample_changed;
  assign fifo_din      = {cur_idx[sample_pkg::word_idx_w-1:0],
                          sample_data[sample_pkg::word_sample_w-1:0]};

  // A write in the same cycle as consumption wins, so no command is lost.
  always_ff @(posedge clk) begin
    if (rst) begin
      command <= '0;
    end else if (command_wr) begin
      command <= cmd.data;
    end else if (clr_command) begin
      command <= '0;
    end
  end

  // Unit list, stored samples and visit index.
  always_ff @(posedge clk) begin
    if (rst || clr_units) begin
      num_units <= '0;
      cur_idx   <= '0;
      for (int i = 0; i < sample_pkg::max_units; i++) begin
        unit_list[i]    <= sample_pkg::no_channel;
        last_fetched[i] <= '0; // Any nonzero sample counts as new after a reset.
      end
    end else begin
      if (new_unit_wr) begin
        unit_list[sample_pkg::unit_idx_t'(num_units)] <= sample_pkg::channel_t'(cmd.data);
        num_units <= num_units + 1'b1;
      end
      if (fifo_wr) begin
        last_fetched[cur_idx] <= sample_data; // Updates even when the FIFO drops the word.
      end
      if (inc_idx) begin
        if (cur_idx == last_idx) begin
          cur_idx <= '0;
        end else begin
          cur_idx <= cur_idx + 1'b1;
        end
      end
    end
  end

endmodule

// ==== hdl/channel_sample_bank.sv ====
`timescale 1ns/1ns
// Channel sample bank.
// Stands in for the data paths of the collection units. While the strobe
// is high it captures the external sample of the selected channel, or zero
// when no source carries that channel number, and holds it otherwise.
module channel_sample_bank #(
  parameter int num_sources = 8 // Number of external sample inputs.
) (
  input  logic                 clk,
  input  logic                 rst,
  input  sample_pkg::channel_t channel_select,
  input  logic                 sample_strobe,
  input  sample_pkg::sample_t  unit_samples [num_sources],
  output sample_pkg::sample_t  sample_data
);

  sample_pkg::sample_t selected; // Value of the selected source.

  // Channels at or above num_sources match no input and read as zero.
  // The unused-entry marker is one of them.
  always_comb begin
    selected = '0;
    for (int i = 0; i < num_sources; i++) begin
      if (channel_select == sample_pkg::channel_t'(i)) begin
        selected = unit_samples[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sample_data <= '0;
    end else if (sample_strobe) begin
      sample_data <= selected; // Fresh data is set up only on request.
    end
  end

endmodule

// ==== hdl/sample_fifo.sv ====
`timescale 1ns/1ns
// Sample FIFO.
// Synchronous first-word-fall-through buffer for collector words.
// The head is visible on dout whenever the FIFO holds data; writes while
// full and reads while empty are ignored.
module sample_fifo #(
  parameter int fifo_depth_log2 = 4 // Depth is two to this power.
) (
  input  logic                     clk,
  input  logic                     rst,
  input  sample_pkg::fifo_word_t   din,
  input  logic                     wr,
  input  logic                     rd,
  output sample_pkg::fifo_word_t   dout,
  output sample_pkg::fifo_status_t status
);

  typedef logic [fifo_depth_log2-1:0] ptr_t;
  typedef logic [fifo_depth_log2:0]   count_t;

  localparam count_t count_full        = {1'b1, {fifo_depth_log2{1'b0}}};
  localparam count_t count_almost_full = {1'b0, {fifo_depth_log2{1'b1}}};

  sample_pkg::fifo_word_t mem [2**fifo_depth_log2];

  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  count_t count;  // Number of words held.
  logic   do_wr;  // Accepted write.
  logic   do_rd;  // Accepted read.

  assign do_wr = wr && !status.full;
  assign do_rd = rd && !status.empty;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1; // Pointers wrap naturally at the depth.
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  assign dout = mem[rd_ptr]; // No read latency.

  assign status.empty        = (count == '0);
  assign status.almost_empty = (count[fifo_depth_log2:1] == '0); // One word or none.
  assign status.full         = (count == count_full);
  assign status.almost_full  = (count >= count_almost_full);

endmodule

// ==== hdl/sample_pkg.sv ====
// Sampling-storage shared definitions.
// Widths with a meaning, the command-bus and FIFO status structs, register
// offsets, command codes and the collector state encoding.
package sample_pkg;

  typedef logic [15:0] cmd_addr_t;   // Upper byte is block position, lower byte is offset.
  typedef logic [31:0] cmd_data_t;   // Command-bus write data.
  typedef logic [7:0]  channel_t;    // Channel number of a collection unit.
  typedef logic [31:0] sample_t;     // One sample as delivered by a unit.
  typedef logic [15:0] fifo_word_t;  // Unit index on top, sample bits below.
  typedef logic [3:0]  unit_idx_t;   // Index into the unit list.

  typedef struct packed {
    cmd_addr_t addr;
    cmd_data_t data;
    logic      cs;  // Chip select, qualifies the whole bus.
    logic      wr;  // Single-cycle write strobe.
  } cmd_bus_t;

  typedef struct packed {
    logic empty;
    logic almost_empty;
    logic full;
    logic almost_full;
  } fifo_status_t;

  localparam int max_units     = 16; // Size of the unit list.
  localparam int word_idx_w    = 3;  // Unit index bits kept in a FIFO word.
  localparam int word_sample_w = 13; // Sample bits kept in a FIFO word.

  localparam logic [7:0] addr_new_unit      = 8'd4; // Appends a channel to the list.
  localparam logic [7:0] addr_local_command = 8'd5; // Latches a command code.

  localparam cmd_data_t cmd_start = 32'd1;
  localparam cmd_data_t cmd_stop  = 32'd2;
  localparam cmd_data_t cmd_reset = 32'd5;

  localparam channel_t no_channel = 8'd255; // Marks an unused list entry.

  typedef enum logic [2:0] {
    idle,
    fetch,
    fetch_wait,
    store,
    increment
  } collect_state_t;

endpackage
